// File: files.f
src/rider_status_pkg.sv
src/soft_error_monitor.sv
src/trigger_counter.sv
src/status_reg_block.sv
src/status_subsystem_top.sv
tb/status_checker.sv
tb/tb_status_top.sv

// File: tb/status_testdata.txt
# cmd and hex operands: thr <corrupt> <unknown> <overflow> | brd <bits> | evt <src> <n>
# trg <accept> <n> | rdo | idl <n> | rd <addr> <expected> | tsa | tsd <cycles>
brd a
rd 00 a0040207
rd 02 00000000
rd 15 00000000
brd 5
rd 00 50040207
thr 00000005 00000000 00000003
rd 0f 00000005
rd 11 00000000
rd 13 00000003
evt 0 4
rd 10 00000004
rd 01 00000000
evt 0 1
rd 01 00000001
evt 0 3
rd 10 00000008
rd 01 00000001
evt 1 7
rd 12 00000007
evt 2 3
rd 14 00000003
rd 01 00000005
trg 1 3
trg 0 2
rd 1d 00000005
rd 1f 00000003
rd 0b 00000003
rd 1e 00000000
rdo
rd 1e 00000003
trg 1 4
trg 0 1
rdo
rd 1e 00000004
rd 1f 00000007
rd 1d 0000000a
# tsa is two one-cycle reads, so 2 + 10 idle + 1 pulse cycle apart
trg 1 1
tsa
idl a
trg 1 1
tsd 0000000d
rd 0d 00000000
rdo
rd 1e 00000002
rd 1f 00000009
rd 0b 00000009

// File: tb/tb_status_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_status_top;

  import rider_status_pkg::*;

  localparam int RD_TIMEOUT = 20;
  localparam int MAX_LINES  = 500;

  logic            clk;
  logic            rst_n;
  board_status_t   board_status;
  soft_err_thres_t thresholds;
  logic            data_corrupt_evt;
  logic            unknown_ttc_evt;
  logic            ddr3_overflow_evt;
  logic            ext_trig;
  logic            accept_triggers;
  logic            readout_done;
  logic            rd_en;
  logic [4:0]      rd_addr;
  logic            rd_valid;
  logic [31:0]     rd_data;

  logic [43:0]     ts_ref;

  status_subsystem_top #(
    .COUNT_WIDTH (32),
    .TS_WIDTH    (44)
  ) uut (
    .clk               (clk),
    .rst_n             (rst_n),
    .board_status      (board_status),
    .thresholds        (thresholds),
    .data_corrupt_evt  (data_corrupt_evt),
    .unknown_ttc_evt   (unknown_ttc_evt),
    .ddr3_overflow_evt (ddr3_overflow_evt),
    .ext_trig          (ext_trig),
    .accept_triggers   (accept_triggers),
    .readout_done      (readout_done),
    .rd_en             (rd_en),
    .rd_addr           (rd_addr),
    .rd_valid          (rd_valid),
    .rd_data           (rd_data)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_on_failure();
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic fail_run(input string why);
    $display("ERROR at %0t ns: %s", $time, why);
    stop_on_failure();
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      stop_on_failure();
    end
  endtask

  // Any assertion failure in the bound checker ends the run
  always @(negedge clk) begin
    if (uut.u_status_checker.fail_count != 0) begin
      fail_run("an assertion in the bound checker failed");
    end
  end

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Source 0 data corrupt, 1 unknown TTC, 2 DDR3 overflow
  task automatic set_event(input int src, input logic val);
    case (src)
      0: data_corrupt_evt = val;
      1: unknown_ttc_evt = val;
      2: ddr3_overflow_evt = val;
      default: fail_run($sformatf("event source %0d does not exist", src));
    endcase
  endtask

  // Random gaps between pulses, none after the last one
  task automatic pulse_event(input int src, input int n);
    int gap;
    for (int i = 0; i < n; i++) begin
      set_event(src, 1'b1);
      @(negedge clk);
      set_event(src, 1'b0);
      if (i < n - 1) begin
        gap = $urandom % 4;
        idle_cycles(gap);
      end
    end
  endtask

  // accept_triggers stays at the last level driven
  task automatic pulse_trigger(input logic acc, input int n);
    int gap;
    accept_triggers = acc;
    for (int i = 0; i < n; i++) begin
      ext_trig = 1'b1;
      @(negedge clk);
      ext_trig = 1'b0;
      if (i < n - 1) begin
        gap = $urandom % 4;
        idle_cycles(gap);
      end
    end
  endtask

  task automatic pulse_readout();
    readout_done = 1'b1;
    @(negedge clk);
    readout_done = 1'b0;
  endtask

  // One strobe, then wait for the reply
  task automatic read_word(input logic [4:0] addr, output logic [31:0] data);
    int wait_cnt;
    rd_en   = 1'b1;
    rd_addr = addr;
    @(negedge clk);
    rd_en    = 1'b0;
    wait_cnt = 0;
    while (!rd_valid && wait_cnt < RD_TIMEOUT) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (!rd_valid) begin
      fail_run($sformatf("no rd_valid within %0d cycles of reading address %0d",
                         RD_TIMEOUT, addr));
    end
    data = rd_data;
  endtask

  // Registers 12 and 13 joined into the 44-bit timestamp
  task automatic read_timestamp(output logic [43:0] ts);
    logic [31:0] lsb;
    logic [31:0] msb;
    read_word(5'd12, lsb);
    read_word(5'd13, msb);
    ts = {msb[11:0], lsb};
  endtask

  initial begin
    int          fd;
    int          code;
    int          lines;
    logic [31:0] cmd;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] op_c;
    logic [31:0] data;
    logic [43:0] ts_now;
    logic [43:0] ts_delta;
    logic [8*200-1:0] rest;

    ts_ref = '0;
    code   = $urandom(52577);

    rst_n             = 1'b0;
    board_status      = '0;
    thresholds        = '0;
    data_corrupt_evt  = 1'b0;
    unknown_ttc_evt   = 1'b0;
    ddr3_overflow_evt = 1'b0;
    ext_trig          = 1'b0;
    accept_triggers   = 1'b0;
    readout_done      = 1'b0;
    rd_en             = 1'b0;
    rd_addr           = '0;

    // Four rising edges in reset
    idle_cycles(4);
    rst_n = 1'b1;

    fd = $fopen("tb/status_testdata.txt", "r");
    if (fd == 0) begin
      fail_run("could not open tb/status_testdata.txt");
    end

    lines = 0;
    while (lines < MAX_LINES) begin
      code = $fscanf(fd, "%s", cmd);
      if (code != 1) begin
        break;
      end
      lines++;
      if (cmd == "#") begin
        code = $fgets(rest, fd);
      end else if (cmd == "thr") begin
        code = $fscanf(fd, "%h %h %h", op_a, op_b, op_c);
        if (code != 3) fail_run("thr line needs three thresholds");
        thresholds.thres_data_corrupt  = op_a;
        thresholds.thres_unknown_ttc   = op_b;
        thresholds.thres_ddr3_overflow = op_c;
      end else if (cmd == "brd") begin
        code = $fscanf(fd, "%h", op_a);
        if (code != 1) fail_run("brd line needs the board status bits");
        board_status = board_status_t'(op_a[3:0]);
      end else if (cmd == "evt") begin
        code = $fscanf(fd, "%h %h", op_a, op_b);
        if (code != 2) fail_run("evt line needs a source and a count");
        pulse_event(int'(op_a), int'(op_b));
      end else if (cmd == "trg") begin
        code = $fscanf(fd, "%h %h", op_a, op_b);
        if (code != 2) fail_run("trg line needs an accept level and a count");
        pulse_trigger(op_a[0], int'(op_b));
      end else if (cmd == "rdo") begin
        pulse_readout();
      end else if (cmd == "idl") begin
        code = $fscanf(fd, "%h", op_a);
        if (code != 1) fail_run("idl line needs a cycle count");
        idle_cycles(int'(op_a));
      end else if (cmd == "rd") begin
        code = $fscanf(fd, "%h %h", op_a, op_b);
        if (code != 2) fail_run("rd line needs an address and an expected value");
        read_word(op_a[4:0], data);
        check_value($sformatf("rd_data[%0d]", op_a[4:0]), data, op_b);
      end else if (cmd == "tsa") begin
        read_timestamp(ts_ref);
      end else if (cmd == "tsd") begin
        code = $fscanf(fd, "%h", op_a);
        if (code != 1) fail_run("tsd line needs a cycle count");
        read_timestamp(ts_now);
        ts_delta = ts_now - ts_ref;
        check_value("trig_timestamp delta", ts_delta[31:0], op_a);
      end else begin
        fail_run($sformatf("unknown command %0s in the test data file", cmd));
      end
    end
    $fclose(fd);

    idle_cycles(2);
    if (uut.u_status_checker.fail_count == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      fail_run("an assertion in the bound checker failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb/status_checker.sv
`timescale 1ns/1ps
`default_nettype none

module status_checker (
  input logic        clk,
  input logic        rst_n,
  input logic        rd_en,
  input logic        rd_valid,
  // Bit 0 data corrupt, bit 1 unknown TTC, bit 2 DDR3 overflow
  input logic [2:0]  err_flags,
  input logic [31:0] raw_count
);

  // Number of assertion failures so far
  int fail_count = 0;

  // Every read strobe gets its reply on the next cycle
  a_valid_after_rd: assert property (@(posedge clk) disable iff (!rst_n) rd_en |=> rd_valid)
    else begin
      $error("rd_valid missing one cycle after rd_en");
      fail_count = fail_count + 1;
    end

  // No reply without a strobe
  a_no_stray_valid: assert property (@(posedge clk) disable iff (!rst_n) !rd_en |=> !rd_valid)
    else begin
      $error("rd_valid high without a preceding rd_en");
      fail_count = fail_count + 1;
    end

  // Reset holds the read port quiet
  a_valid_low_in_reset: assert property (@(posedge clk) !rst_n |=> !rd_valid)
    else begin
      $error("rd_valid high during reset");
      fail_count = fail_count + 1;
    end

  // Sticky flags, only reset may clear them
  a_flags_sticky: assert property (@(posedge clk) disable iff (!rst_n)
      (err_flags & $past(err_flags)) == $past(err_flags))
    else begin
      $error("soft error flag fell while out of reset");
      fail_count = fail_count + 1;
    end

  // Raw trigger count only moves up
  a_raw_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
      raw_count >= $past(raw_count))
    else begin
      $error("raw trigger count decreased");
      fail_count = fail_count + 1;
    end

endmodule

bind status_subsystem_top status_checker u_status_checker (
  .clk       (clk),
  .rst_n     (rst_n),
  .rd_en     (rd_en),
  .rd_valid  (rd_valid),
  .err_flags ({soft_err.error_ddr3_overflow, soft_err.error_unknown_ttc,
               soft_err.error_data_corrupt}),
  .raw_count (trig.raw_ext_trigger_count)
);

`default_nettype wire

// File: src/status_subsystem_top.sv
`timescale 1ns/1ps
`default_nettype none

module status_subsystem_top #(
  parameter int COUNT_WIDTH = 32,
  parameter int TS_WIDTH    = 44
) (
  input  logic                              clk,
  input  logic                              rst_n,
  // Static board levels
  input  rider_status_pkg::board_status_t   board_status,
  // Soft error limits from the control register file
  input  rider_status_pkg::soft_err_thres_t thresholds,
  // Soft error strobes
  input  logic                              data_corrupt_evt,
  input  logic                              unknown_ttc_evt,
  input  logic                              ddr3_overflow_evt,
  // Front panel trigger path
  input  logic                              ext_trig,
  input  logic                              accept_triggers,
  input  logic                              readout_done,
  // Slow-control read port
  input  logic                              rd_en,
  input  logic [4:0]                        rd_addr,
  output logic                              rd_valid,
  output logic [31:0]                       rd_data
);

  import rider_status_pkg::*;

  soft_err_status_t soft_err;
  trig_status_t     trig;

  // Saturating soft error counters and sticky flags
  soft_error_monitor #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) u_soft_error_monitor (
    .clk               (clk),
    .rst_n             (rst_n),
    .data_corrupt_evt  (data_corrupt_evt),
    .unknown_ttc_evt   (unknown_ttc_evt),
    .ddr3_overflow_evt (ddr3_overflow_evt),
    .thresholds        (thresholds),
    .status            (soft_err)
  );

  // Raw, accepted and per-readout trigger counts with timestamp
  trigger_counter #(
    .TS_WIDTH (TS_WIDTH)
  ) u_trigger_counter (
    .clk             (clk),
    .rst_n           (rst_n),
    .ext_trig        (ext_trig),
    .accept_triggers (accept_triggers),
    .readout_done    (readout_done),
    .status          (trig)
  );

  // 32-word status map behind the read port
  status_reg_block u_status_reg_block (
    .clk          (clk),
    .rst_n        (rst_n),
    .rd_en        (rd_en),
    .rd_addr      (reg_addr_e'(rd_addr)),
    .board_status (board_status),
    .thresholds   (thresholds),
    .soft_err     (soft_err),
    .trig         (trig),
    .rd_valid     (rd_valid),
    .rd_data      (rd_data)
  );

endmodule

`default_nettype wire

// File: src/status_reg_block.sv
`timescale 1ns/1ps
`default_nettype none

module status_reg_block (
  input  logic                               clk,
  input  logic                               rst_n,
  // Slow-control read port, strobe with fixed one-cycle reply
  input  logic                               rd_en,
  input  rider_status_pkg::reg_addr_e        rd_addr,
  // Status sources
  input  rider_status_pkg::board_status_t    board_status,
  input  rider_status_pkg::soft_err_thres_t  thresholds,
  input  rider_status_pkg::soft_err_status_t soft_err,
  input  rider_status_pkg::trig_status_t     trig,
  output logic                               rd_valid,
  output logic [31:0]                        rd_data
);

  import rider_status_pkg::*;

  logic [31:0] rd_word;

  // Word selected by the current address
  always_comb begin
    rd_word = '0;
    case (rd_addr)
      // Board levels on top, version in the low 24 bits
      REG_FPGA_STATUS: begin
        rd_word = {board_status.is_golden, board_status.prog_chan_done,
                   board_status.async_mode, board_status.cbuf_mode,
                   4'd0, MAJOR_REV, MINOR_REV, PATCH_REV};
      end
      // Soft error flags, data corrupt in bit 0
      REG_ERROR: begin
        rd_word = {29'd0, soft_err.error_ddr3_overflow,
                   soft_err.error_unknown_ttc, soft_err.error_data_corrupt};
      end
      REG_TRIG_NUM: begin
        rd_word = {8'd0, trig.trig_num};
      end
      // Timestamp split over two words
      REG_TS_LSB: begin
        rd_word = trig.trig_timestamp[31:0];
      end
      REG_TS_MSB: begin
        rd_word = {20'd0, trig.trig_timestamp[43:32]};
      end
      // Thresholds next to their counts
      REG_THRES_CORRUPT: begin
        rd_word = thresholds.thres_data_corrupt;
      end
      REG_CNT_CORRUPT: begin
        rd_word = soft_err.cs_mismatch_count;
      end
      REG_THRES_UNKNOWN: begin
        rd_word = thresholds.thres_unknown_ttc;
      end
      REG_CNT_UNKNOWN: begin
        rd_word = soft_err.unknown_cmd_count;
      end
      REG_THRES_OVERFLOW: begin
        rd_word = thresholds.thres_ddr3_overflow;
      end
      REG_CNT_OVERFLOW: begin
        rd_word = soft_err.ddr3_overflow_count;
      end
      // Front panel trigger counters
      REG_RAW_TRIG: begin
        rd_word = trig.raw_ext_trigger_count;
      end
      REG_LAST_READOUT: begin
        rd_word = {8'd0, trig.pulse_trigs_last_readout};
      end
      REG_ACCEPTED_TRIG: begin
        rd_word = trig.accepted_ext_trigger_count;
      end
      // Unused indices read zero
      default: begin
        rd_word = '0;
      end
    endcase
  end

  // Valid follows each strobe by one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= rd_en;
    end
  end

  // Capture the word as it stood at the strobe edge
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= rd_word;
    end
  end

endmodule

`default_nettype wire

// File: src/trigger_counter.sv
`timescale 1ns/1ps
`default_nettype none

module trigger_counter #(
  parameter int TS_WIDTH = 44
) (
  input  logic                           clk,
  input  logic                           rst_n,
  // One-cycle pulse per front panel trigger
  input  logic                           ext_trig,
  // Level, gates which triggers count as accepted
  input  logic                           accept_triggers,
  // One-cycle pulse when a readout completes
  input  logic                           readout_done,
  output rider_status_pkg::trig_status_t status
);

  logic                accepted;
  logic [TS_WIDTH-1:0] ts_count;
  logic [TS_WIDTH-1:0] ts_latch;
  logic [31:0]         raw_count;
  logic [31:0]         acc_count;
  logic [23:0]         trig_num;
  logic [23:0]         tally;
  logic [23:0]         last_tally;

  assign accepted = ext_trig & accept_triggers;

  // Free-running time base, starts at zero out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ts_count <= '0;
    end else begin
      ts_count <= ts_count + 1'b1;
    end
  end

  // Raw count sees every pulse regardless of accept
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      raw_count <= '0;
    end else if (ext_trig) begin
      raw_count <= raw_count + 1'b1;
    end
  end

  // Accepted triggers get a number and a timestamp
  // trig_num wraps at 24 bits
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc_count <= '0;
      trig_num  <= '0;
      ts_latch  <= '0;
    end else if (accepted) begin
      acc_count <= acc_count + 1'b1;
      trig_num  <= trig_num + 1'b1;
      ts_latch  <= ts_count;
    end
  end

  // Tally of accepted triggers since the previous readout
  // A trigger coinciding with readout_done opens the new interval
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tally      <= '0;
      last_tally <= '0;
    end else if (readout_done) begin
      last_tally <= tally;
      tally      <= accepted ? 24'd1 : 24'd0;
    end else if (accepted) begin
      tally <= tally + 1'b1;
    end
  end

  always_comb begin
    status                            = '0;
    status.raw_ext_trigger_count      = raw_count;
    status.accepted_ext_trigger_count = acc_count;
    status.trig_num                   = trig_num;
    // Fit the time base to the 44-bit field
    status.trig_timestamp             = 44'(ts_latch);
    status.pulse_trigs_last_readout   = last_tally;
  end

endmodule

`default_nettype wire

// File: src/soft_error_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module soft_error_monitor #(
  parameter int COUNT_WIDTH = 32
) (
  input  logic                               clk,
  input  logic                               rst_n,
  // Single-cycle event strobes
  input  logic                               data_corrupt_evt,
  input  logic                               unknown_ttc_evt,
  input  logic                               ddr3_overflow_evt,
  // Limits from the control register file
  input  rider_status_pkg::soft_err_thres_t  thresholds,
  output rider_status_pkg::soft_err_status_t status
);

  // Index 0 data corrupt, 1 unknown TTC, 2 DDR3 overflow
  localparam int NUM_SRC = 3;

  logic [NUM_SRC-1:0]     evt;
  logic [31:0]            thres [NUM_SRC];
  logic [COUNT_WIDTH-1:0] count [NUM_SRC];
  logic                   flag  [NUM_SRC];

  assign evt = {ddr3_overflow_evt, unknown_ttc_evt, data_corrupt_evt};

  assign thres[0] = thresholds.thres_data_corrupt;
  assign thres[1] = thresholds.thres_unknown_ttc;
  assign thres[2] = thresholds.thres_ddr3_overflow;

  // Same counter and flag logic for every source
  for (genvar i = 0; i < NUM_SRC; i++) begin : g_src
    logic [COUNT_WIDTH-1:0] count_next;
    logic                   at_max;
    logic                   limit_hit;

    // Hold at all ones instead of wrapping back to zero
    assign at_max     = &count[i];
    assign count_next = at_max ? count[i] : count[i] + 1'b1;

    // Compare against the value this strobe produces
    // Widths differ, so the shorter side is zero-extended
    assign limit_hit = (thres[i] != '0) && (count_next >= thres[i]);

    always_ff @(posedge clk) begin
      if (!rst_n) begin
        count[i] <= '0;
        flag[i]  <= 1'b0;
      end else if (evt[i]) begin
        count[i] <= count_next;
        // Sticky, only reset clears it
        if (limit_hit) begin
          flag[i] <= 1'b1;
        end
      end
    end
  end

  // Present counts as 32-bit words for the status map
  always_comb begin
    status                     = '0;
    status.cs_mismatch_count   = 32'(count[0]);
    status.unknown_cmd_count   = 32'(count[1]);
    status.ddr3_overflow_count = 32'(count[2]);
    status.error_data_corrupt  = flag[0];
    status.error_unknown_ttc   = flag[1];
    status.error_ddr3_overflow = flag[2];
  end

endmodule

`default_nettype wire

// File: src/rider_status_pkg.sv
`default_nettype none

package rider_status_pkg;

  // Firmware version fields shown in register 00
  localparam logic [7:0] MAJOR_REV = 8'd4;
  localparam logic [7:0] MINOR_REV = 8'd2;
  localparam logic [7:0] PATCH_REV = 8'd7;

  // Status map indices in use
  // Any index not listed here reads as zero
  typedef enum logic [4:0] {
    REG_FPGA_STATUS    = 5'd0,
    REG_ERROR          = 5'd1,
    REG_TRIG_NUM       = 5'd11,
    REG_TS_LSB         = 5'd12,
    REG_TS_MSB         = 5'd13,
    REG_THRES_CORRUPT  = 5'd15,
    REG_CNT_CORRUPT    = 5'd16,
    REG_THRES_UNKNOWN  = 5'd17,
    REG_CNT_UNKNOWN    = 5'd18,
    REG_THRES_OVERFLOW = 5'd19,
    REG_CNT_OVERFLOW   = 5'd20,
    REG_RAW_TRIG       = 5'd29,
    REG_LAST_READOUT   = 5'd30,
    REG_ACCEPTED_TRIG  = 5'd31
  } reg_addr_e;

  // Static board levels, MSB first as they appear in register 00
  typedef struct packed {
    logic is_golden;
    logic prog_chan_done;
    logic async_mode;
    logic cbuf_mode;
  } board_status_t;

  // Programmable soft error limits, zero disables a flag
  typedef struct packed {
    logic [31:0] thres_data_corrupt;
    logic [31:0] thres_unknown_ttc;
    logic [31:0] thres_ddr3_overflow;
  } soft_err_thres_t;

  // Counts and sticky flags from the soft error monitor
  typedef struct packed {
    logic [31:0] cs_mismatch_count;
    logic [31:0] unknown_cmd_count;
    logic [31:0] ddr3_overflow_count;
    logic        error_data_corrupt;
    logic        error_unknown_ttc;
    logic        error_ddr3_overflow;
  } soft_err_status_t;

  // Front panel trigger bookkeeping
  typedef struct packed {
    logic [31:0] raw_ext_trigger_count;
    logic [31:0] accepted_ext_trigger_count;
    logic [23:0] trig_num;
    logic [43:0] trig_timestamp;
    logic [23:0] pulse_trigs_last_readout;
  } trig_status_t;

endpackage

`default_nettype wire
